/* Makefile */
VERILATOR ?= verilator
TOP       ?= hamming_codec_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All checks passed

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* hamming_block_corrector.sv */
`timescale 1ns/1ns

// Syndrome check, single-bit fix and data extraction for a received block
module hamming_block_corrector import hamming_pkg::*; (
  input  logic [block_width-1:0]    block,
  output logic                      error,
  output logic [block_width-1:0]    corrected_block,
  output logic [position_width-1:0] corrected_error_position,
  output logic [data_width-1:0]     data
);

  // Pull the data bits out of a block
  // Same walk as the encoder, just in reverse
  function automatic logic [data_width-1:0] extract_data(input logic [block_width-1:0] blk);
    logic [data_width-1:0] result;
    int unsigned           data_index;
    result = '0;
    data_index = 0;
    for (int pos = 1; pos <= block_width; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        result[data_index] = blk[pos-1];
        data_index = data_index + 1;
      end
    end
    return result;
  endfunction

  // Data and parity as they arrived
  logic [data_width-1:0]   received_data;
  logic [parity_width-1:0] received_code;

  // Parity recomputed from the received data
  logic [parity_width-1:0] expected_code;

  // Points at the flipped position, zero if clean
  logic [parity_width-1:0] syndrome;

  // One-hot flip mask for the bad bit
  logic [block_width-1:0] error_mask;

  assign received_data = extract_data(block);

  // Parity bit k lives at position 2^k
  always_comb begin
    for (int k = 0; k < parity_width; k++) begin
      received_code[k] = block[(1 << k) - 1];
    end
  end

  // Only the parity output is needed here
  hamming_encoder encoder (
    .data  (received_data),
    .code  (expected_code),
    .block ()
  );

  assign syndrome = received_code ^ expected_code;
  assign error    = |syndrome;

  // Every nonzero syndrome is a legal position for a 15-bit block
  always_comb begin
    corrected_error_position = '0;
    error_mask = '0;
    if (error) begin
      corrected_error_position = syndrome - 1'b1;
      error_mask[corrected_error_position] = 1'b1;
    end
  end

  assign corrected_block = block ^ error_mask;

  // Data comes from the fixed block, not the received one
  assign data = extract_data(corrected_block);

endmodule

/* hamming_codec_asserts.sv */
`timescale 1ns/1ns

// Concurrent checks bound onto the codec top level
module hamming_codec_asserts import hamming_pkg::*; (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   stats_clear,
  input logic                   res_valid,
  input hamming_op_e            res_op,
  input logic                   res_error,
  input logic [stats_width-1:0] decoded_count,
  input logic [stats_width-1:0] corrected_count
);

  // Running total of assertion failures
  int failure_count = 0;

  // A reset edge never leaves a result strobe behind
  assert property (@(posedge clk) !rst_n |=> !res_valid)
    else begin
      failure_count++;
      $error("res_valid high after a reset edge");
    end

  // Encode has nothing to correct
  assert property (@(posedge clk) disable iff (!rst_n)
    (res_valid && res_op == op_encode) |-> !res_error)
    else begin
      failure_count++;
      $error("error flag set on an encode result");
    end

  // Counters only go down through a clear
  assert property (@(posedge clk) disable iff (!rst_n)
    !$past(stats_clear) |-> (decoded_count >= $past(decoded_count)))
    else begin
      failure_count++;
      $error("decoded_count dropped without stats_clear");
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    !$past(stats_clear) |-> (corrected_count >= $past(corrected_count)))
    else begin
      failure_count++;
      $error("corrected_count dropped without stats_clear");
    end

endmodule

/* hamming_codec_tb.sv */
`timescale 1ns/1ns

// Testbench for the Hamming codec top level
module hamming_codec_tb import hamming_pkg::*; ();

  localparam int          num_commands  = 400;
  localparam int          reset_cycles  = 16;
  localparam int          drain_timeout = 20;
  localparam logic [31:0] lfsr_seed     = 32'd78263;

  // One expected result and the cycle it is due in
  typedef struct {
    int                        due;
    hamming_op_e               op;
    logic [block_width-1:0]    word;
    logic [data_width-1:0]     data;
    logic                      error;
    logic [position_width-1:0] position;
  } expect_t;

  logic                      clk;
  logic                      rst_n;
  logic                      cmd_valid;
  hamming_op_e               cmd_op;
  logic [block_width-1:0]    cmd_word;
  logic                      stats_clear;
  logic                      res_valid;
  hamming_op_e               res_op;
  logic [block_width-1:0]    res_word;
  logic [data_width-1:0]     res_data;
  logic                      res_error;
  logic [position_width-1:0] res_position;
  logic [stats_width-1:0]    decoded_count;
  logic [stats_width-1:0]    corrected_count;

  // Model state
  expect_t                expected_q[$];
  logic [stats_width-1:0] exp_decoded = '0;
  logic [stats_width-1:0] exp_corrected = '0;
  logic [31:0]            lfsr_state = lfsr_seed;
  int                     cycle = 0;
  int                     value_errors = 0;
  int                     other_errors = 0;

  hamming_codec_top DUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd_valid       (cmd_valid),
    .cmd_op          (cmd_op),
    .cmd_word        (cmd_word),
    .stats_clear     (stats_clear),
    .res_valid       (res_valid),
    .res_op          (res_op),
    .res_word        (res_word),
    .res_data        (res_data),
    .res_error       (res_error),
    .res_position    (res_position),
    .decoded_count   (decoded_count),
    .corrected_count (corrected_count)
  );

  bind hamming_codec_top hamming_codec_asserts asserts (
    .clk             (clk),
    .rst_n           (rst_n),
    .stats_clear     (stats_clear),
    .res_valid       (res_valid),
    .res_op          (res_op),
    .res_error       (res_error),
    .decoded_count   (decoded_count),
    .corrected_count (corrected_count)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Rising edge count that the falling edge checks read
  always @(posedge clk) cycle <= cycle + 1;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // One step per bit taken
  function automatic logic [31:0] next_random(input int nbits);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // Reference encoder
  // Data in non-power-of-two positions, parity k over positions with bit k set
  function automatic logic [block_width-1:0] encode_block(input logic [data_width-1:0] data);
    logic [block_width-1:0] blk;
    logic                   parity;
    int                     d;
    blk = '0;
    d = 0;
    for (int p = 1; p <= block_width; p++) begin
      if (p != 1 && p != 2 && p != 4 && p != 8) begin
        blk[p-1] = data[d];
        d++;
      end
    end
    for (int k = 0; k < parity_width; k++) begin
      parity = 1'b0;
      for (int p = 1; p <= block_width; p++) begin
        if (p != (1 << k) && ((p >> k) & 1) == 1) begin
          parity = parity ^ blk[p-1];
        end
      end
      blk[(1 << k) - 1] = parity;
    end
    return blk;
  endfunction

  task automatic check_op(input string name, input hamming_op_e expected,
                          input hamming_op_e actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %s, actual %s", name, expected.name(), actual.name());
      value_errors++;
    end
  endtask

  task automatic check_block(input string name, input logic [block_width-1:0] expected,
                             input logic [block_width-1:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_data(input string name, input logic [data_width-1:0] expected,
                            input logic [data_width-1:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_position(input string name, input logic [position_width-1:0] expected,
                                input logic [position_width-1:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %b, actual %b", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_count(input string name, input logic [stats_width-1:0] expected,
                             input logic [stats_width-1:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
      value_errors++;
    end
  endtask

  // Checks what the DUT shows on one falling edge and drives the next inputs
  task automatic step(input logic valid, input hamming_op_e op,
                      input logic [block_width-1:0] word, input expect_t entry,
                      input logic clear);
    expect_t head;
    expect_t pending;
    string   tag;
    logic    saw_decode;
    logic    saw_error;
    saw_decode = 1'b0;
    saw_error = 1'b0;
    @(negedge clk);
    check_count("decoded_count", exp_decoded, decoded_count);
    check_count("corrected_count", exp_corrected, corrected_count);
    if (res_valid) begin
      if (expected_q.size() == 0) begin
        $display("Result strobe at cycle %0d with no command in flight", cycle);
        other_errors++;
      end else begin
        head = expected_q.pop_front();
        tag = (head.op == op_decode) ? "decode" : "encode";
        if (head.due != cycle) begin
          $display("A %s result came at cycle %0d, it was due at cycle %0d",
                   tag, cycle, head.due);
          other_errors++;
        end
        check_op({tag, " op"}, head.op, res_op);
        check_block({tag, " word"}, head.word, res_word);
        check_data({tag, " data"}, head.data, res_data);
        check_flag({tag, " error"}, head.error, res_error);
        check_position({tag, " position"}, head.position, res_position);
        saw_decode = (head.op == op_decode);
        saw_error = saw_decode && head.error;
      end
    end else if (expected_q.size() != 0 && expected_q[0].due <= cycle) begin
      $display("No result at cycle %0d for a command due then", cycle);
      other_errors++;
      head = expected_q.pop_front();
    end
    // Counter model for the coming edge with clear taking priority
    if (clear) begin
      exp_decoded = '0;
      exp_corrected = '0;
    end else begin
      if (saw_decode && exp_decoded != '1) exp_decoded = exp_decoded + 1'b1;
      if (saw_error && exp_corrected != '1) exp_corrected = exp_corrected + 1'b1;
    end
    cmd_valid = valid;
    cmd_op = op;
    cmd_word = word;
    stats_clear = clear;
    if (valid) begin
      pending = entry;
      pending.due = cycle + 2;
      expected_q.push_back(pending);
    end
  endtask

  initial begin
    expect_t                idle_entry;
    expect_t                entry;
    hamming_op_e            op;
    logic [data_width-1:0]  data;
    logic [block_width-1:0] word;
    int                     idle;
    int                     flip;
    int                     wait_cycles;
    int                     total;
    rst_n = 1'b0;
    cmd_valid = 1'b0;
    cmd_op = op_encode;
    cmd_word = '0;
    stats_clear = 1'b0;
    idle_entry = '{due: 0, op: op_encode, word: '0, data: '0, error: 1'b0, position: '0};
    for (int i = 0; i < reset_cycles; i++) @(negedge clk);
    check_flag("reset res_valid", 1'b0, res_valid);
    check_count("reset decoded_count", '0, decoded_count);
    check_count("reset corrected_count", '0, corrected_count);
    rst_n = 1'b1;

    for (int n = 0; n < num_commands; n++) begin
      // Half the commands go back to back
      idle = int'(next_random(2));
      if (idle == 3) idle = 0;
      for (int g = 0; g < idle; g++) step(1'b0, op_encode, '0, idle_entry, 1'b0);
      if (n == 150 || n == 300) step(1'b0, op_encode, '0, idle_entry, 1'b1);
      op = (next_random(1) == 32'd1) ? op_decode : op_encode;
      data = data_width'(next_random(data_width));
      entry = idle_entry;
      entry.op = op;
      entry.word = encode_block(data);
      entry.data = data;
      if (op == op_encode) begin
        // Junk in the upper bits must be ignored
        word = block_width'(next_random(block_width - data_width)) << data_width;
        word[data_width-1:0] = data;
      end else begin
        word = entry.word;
        if (next_random(1) == 32'd1) begin
          flip = int'(next_random(position_width)) % block_width;
          word[flip] = ~word[flip];
          entry.error = 1'b1;
          entry.position = position_width'(flip);
        end
      end
      step(1'b1, op, word, entry, 1'b0);
    end

    wait_cycles = 0;
    while (expected_q.size() != 0 && wait_cycles < drain_timeout) begin
      step(1'b0, op_encode, '0, idle_entry, 1'b0);
      wait_cycles++;
    end
    if (expected_q.size() != 0) begin
      $display("Timed out with %0d results never seen", expected_q.size());
      other_errors++;
    end else begin
      // Let the last counter update land and get compared
      step(1'b0, op_encode, '0, idle_entry, 1'b0);
    end
    total = value_errors + other_errors + DUT.asserts.failure_count;
    $display("Errors: %0d value, %0d other, %0d assertion", value_errors, other_errors,
             DUT.asserts.failure_count);
    if (total == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* hamming_codec_top.sv */
`timescale 1ns/1ns

// Codec top level
// Command in, result and statistics out, all on plain ports
module hamming_codec_top import hamming_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,

  // Command strobe with opcode and word
  input  logic                      cmd_valid,
  input  hamming_op_e               cmd_op,
  input  logic [block_width-1:0]    cmd_word,

  // Level, clears both counters on the next edge
  input  logic                      stats_clear,

  // Result, two edges after the command
  output logic                      res_valid,
  output hamming_op_e               res_op,
  output logic [block_width-1:0]    res_word,
  output logic [data_width-1:0]     res_data,
  output logic                      res_error,
  output logic [position_width-1:0] res_position,

  // Statistics
  output logic [stats_width-1:0]    decoded_count,
  output logic [stats_width-1:0]    corrected_count
);

  // Result bus shared by datapath and statistics
  hamming_result_if result_bus ();

  hamming_datapath datapath (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_word  (cmd_word),
    .result    (result_bus.source)
  );

  hamming_error_stats stats (
    .clk             (clk),
    .rst_n           (rst_n),
    .stats_clear     (stats_clear),
    .result          (result_bus.monitor),
    .decoded_count   (decoded_count),
    .corrected_count (corrected_count)
  );

  // Break the bus out to the pins
  assign res_valid    = result_bus.valid;
  assign res_op       = result_bus.op;
  assign res_word     = result_bus.word;
  assign res_data     = result_bus.data;
  assign res_error    = result_bus.error;
  assign res_position = result_bus.position;

endmodule

/* hamming_datapath.sv */
`timescale 1ns/1ns

// Two-stage codec pipeline
// Stage one holds the command, stage two holds the result
module hamming_datapath import hamming_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cmd_valid,
  input  hamming_op_e            cmd_op,
  input  logic [block_width-1:0] cmd_word,
  hamming_result_if.source       result
);

  // Stage one command register
  logic                   s1_valid;
  hamming_op_e            s1_op;
  logic [block_width-1:0] s1_word;

  // Encoder view of the stage one word
  logic [block_width-1:0] enc_block;

  // Corrector view of the stage one word
  logic                      dec_error;
  logic [block_width-1:0]    dec_block;
  logic [position_width-1:0] dec_position;
  logic [data_width-1:0]     dec_data;

  // Selected result before the stage two register
  logic [block_width-1:0]    next_word;
  logic [data_width-1:0]     next_data;
  logic                      next_error;
  logic [position_width-1:0] next_position;

  // Stage one
  // Valid bit follows the command strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= cmd_valid;
    end
  end

  // Payload loads only when a command arrives
  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      s1_op   <= cmd_op;
      s1_word <= cmd_word;
    end
  end

  // Encode path sees only the low data bits of the word
  hamming_encoder encoder (
    .data  (s1_word[data_width-1:0]),
    .code  (),
    .block (enc_block)
  );

  hamming_block_corrector corrector (
    .block                    (s1_word),
    .error                    (dec_error),
    .corrected_block          (dec_block),
    .corrected_error_position (dec_position),
    .data                     (dec_data)
  );

  // Pick the path by opcode
  always_comb begin
    if (s1_op == op_decode) begin
      next_word     = dec_block;
      next_data     = dec_data;
      next_error    = dec_error;
      next_position = dec_position;
    end else begin
      // Encode echoes its data and never reports an error
      next_word     = enc_block;
      next_data     = s1_word[data_width-1:0];
      next_error    = 1'b0;
      next_position = '0;
    end
  end

  // Stage two
  // Result fields read zero out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result.valid    <= 1'b0;
      result.op       <= op_encode;
      result.word     <= '0;
      result.data     <= '0;
      result.error    <= 1'b0;
      result.position <= '0;
    end else begin
      result.valid <= s1_valid;
      // Fields hold between results
      if (s1_valid) begin
        result.op       <= s1_op;
        result.word     <= next_word;
        result.data     <= next_data;
        result.error    <= next_error;
        result.position <= next_position;
      end
    end
  end

endmodule

/* hamming_encoder.sv */
`timescale 1ns/1ns

// Parity generation and block packing for one data word
module hamming_encoder import hamming_pkg::*; (
  input  logic [data_width-1:0]   data,
  output logic [parity_width-1:0] code,
  output logic [block_width-1:0]  block
);

  // Walk the Hamming positions in ascending order
  // Data bits fill the non-power-of-two slots one after another
  always_comb begin
    int unsigned data_index;
    data_index = 0;
    code = '0;
    block = '0;
    for (int pos = 1; pos <= block_width; pos++) begin
      // Power-of-two positions are reserved for parity
      if ((pos & (pos - 1)) != 0) begin
        block[pos-1] = data[data_index];
        // Each parity bit covers the positions that have its bit set
        for (int k = 0; k < parity_width; k++) begin
          if (pos[k]) begin
            code[k] = code[k] ^ data[data_index];
          end
        end
        data_index = data_index + 1;
      end
    end
    // Drop parity bit k into position 2^k
    for (int k = 0; k < parity_width; k++) begin
      block[(1 << k) - 1] = code[k];
    end
  end

endmodule

/* hamming_error_stats.sv */
`timescale 1ns/1ns

// Decode statistics
// Counts decoded words and corrected errors, both saturating
module hamming_error_stats import hamming_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   stats_clear,
  hamming_result_if.monitor      result,
  output logic [stats_width-1:0] decoded_count,
  output logic [stats_width-1:0] corrected_count
);

  // Result strobe qualified by opcode
  logic decode_seen;
  logic error_seen;

  assign decode_seen = result.valid && (result.op == op_decode);
  assign error_seen  = decode_seen && result.error;

  // Counters move on the edge after the strobe
  // Clear wins over an increment in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      decoded_count <= '0;
    end else if (stats_clear) begin
      decoded_count <= '0;
    end else if (decode_seen && (decoded_count != '1)) begin
      decoded_count <= decoded_count + 1'b1;
    end
  end

  // Sticks at all ones once full
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      corrected_count <= '0;
    end else if (stats_clear) begin
      corrected_count <= '0;
    end else if (error_seen && (corrected_count != '1)) begin
      corrected_count <= corrected_count + 1'b1;
    end
  end

endmodule

/* hamming_pkg.sv */
// Shared widths and command encoding for the Hamming codec
package hamming_pkg;

  // Block layout for the (15,11) code
  // Bit i of a block holds Hamming position i+1
  localparam int block_width = 15;

  // Parity bits sit at the power-of-two positions 1, 2, 4 and 8
  localparam int parity_width = 4;

  // Everything that is not parity carries data
  localparam int data_width = block_width - parity_width;

  // A corrected bit index covers 0 to block_width-1
  localparam int position_width = 4;

  // Statistics counters
  localparam int stats_width = 16;

  // Command opcodes
  // Encode takes a data word, decode takes a received block
  typedef enum logic [0:0] {
    op_encode = 1'b0,
    op_decode = 1'b1
  } hamming_op_e;

endpackage

/* hamming_result_if.sv */
`timescale 1ns/1ns

// One pipeline result from the datapath to whoever watches it
interface hamming_result_if import hamming_pkg::*; ();

  // Single-cycle strobe, no acknowledge
  logic valid;

  // Opcode of the command that produced this result
  hamming_op_e op;

  // Encoded block or corrected block
  logic [block_width-1:0] word;

  // Echoed data on encode, extracted data on decode
  logic [data_width-1:0] data;

  // Decode found and fixed a single flipped bit
  logic error;

  // 0-based block index of the fixed bit
  logic [position_width-1:0] position;

  // Datapath side drives everything
  modport source (output valid, op, word, data, error, position);

  // Observers only look
  modport monitor (input valid, op, word, data, error, position);

endinterface

/* project.f */
hamming_pkg.sv
hamming_result_if.sv
hamming_encoder.sv
hamming_block_corrector.sv
hamming_datapath.sv
hamming_error_stats.sv
hamming_codec_top.sv
hamming_codec_asserts.sv
hamming_codec_tb.sv
